/* source/ipod_params.svh */
`ifndef IPOD_PARAMS_SVH
`define IPOD_PARAMS_SVH

// ==========================================================================
// Data path widths
// ==========================================================================
`define IPOD_ASCII_W          8
`define IPOD_ADDR_W           23
`define IPOD_WORD_W           32
`define IPOD_SAMPLE_W         8
`define IPOD_DIV_W            16

// ==========================================================================
// Playback rate, in CLK_50M cycles per sample
// ==========================================================================
`define IPOD_DIVISOR_DEFAULT  2272
`define IPOD_DIVISOR_STEP     16
`define IPOD_DIVISOR_MIN      256
`define IPOD_DIVISOR_MAX      8192
`define IPOD_REPEAT_CYCLES    64

// Flash span that is played, then wrapped
`define IPOD_FLASH_WORDS      64
`define IPOD_HEX_DIGITS       4

`endif

/* source/ipod_cmd_pkg.sv */
`default_nettype none

package ipod_cmd_pkg;

  // Player commands, decoded from keyboard ASCII
  //   E play, D pause, F forward, B backward, R restart
  typedef enum logic [2:0]
  {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FORWARD,
    CMD_BACKWARD,
    CMD_RESTART
  } cmd_e;

endpackage

`default_nettype wire

/* source/ipod_flash_pkg.sv */
`default_nettype none

`include "ipod_params.svh"

package ipod_flash_pkg;

  // Read transaction phases of the flash reader
  typedef enum logic [1:0]
  {
    FLASH_IDLE,
    FLASH_REQUEST,
    FLASH_WAIT_DATA
  } flash_state_e;

  typedef logic [`IPOD_ADDR_W-1:0]   flash_addr_t;
  typedef logic [`IPOD_WORD_W-1:0]   flash_word_t;
  typedef logic [`IPOD_SAMPLE_W-1:0] audio_sample_t;

endpackage

`default_nettype wire

/* source/player_command_decoder.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module player_command_decoder
  import ipod_cmd_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  logic [`IPOD_ASCII_W-1:0] kbd_ascii,
  input  logic                     kbd_valid,
  output logic                     paused,
  output logic                     reverse,
  output logic                     restart
);

  logic [`IPOD_ASCII_W-1:0] ascii_upper;
  cmd_e                     cmd;

  // Fold a..z onto A..Z
  always_comb
  begin
    if (kbd_ascii >= 8'h61 && kbd_ascii <= 8'h7A)
      ascii_upper = kbd_ascii - 8'h20;
    else
      ascii_upper = kbd_ascii;
  end

  always_comb
  begin
    cmd = CMD_NONE;
    if (kbd_valid)
    begin
      case (ascii_upper)
        8'h45:   cmd = CMD_PLAY;
        8'h44:   cmd = CMD_PAUSE;
        8'h46:   cmd = CMD_FORWARD;
        8'h42:   cmd = CMD_BACKWARD;
        8'h52:   cmd = CMD_RESTART;
        default: cmd = CMD_NONE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      paused  <= 1'b1;
      reverse <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= (cmd == CMD_RESTART);
      case (cmd)
        CMD_PLAY:     paused  <= 1'b0;
        CMD_PAUSE:    paused  <= 1'b1;
        CMD_FORWARD:  reverse <= 1'b0;
        CMD_BACKWARD: reverse <= 1'b1;
        default:      ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/playback_rate_control.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module playback_rate_control
(
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic [2:0]             key_n,
  output logic [`IPOD_DIV_W-1:0] divisor,
  output logic                   sample_tick
);

  localparam int REP_W = $clog2(`IPOD_REPEAT_CYCLES);

  localparam logic [`IPOD_DIV_W-1:0] DIV_DEFAULT = `IPOD_DIVISOR_DEFAULT;
  localparam logic [`IPOD_DIV_W-1:0] DIV_STEP    = `IPOD_DIVISOR_STEP;
  localparam logic [`IPOD_DIV_W-1:0] DIV_MIN     = `IPOD_DIVISOR_MIN;
  localparam logic [`IPOD_DIV_W-1:0] DIV_MAX     = `IPOD_DIVISOR_MAX;
  localparam logic [REP_W-1:0]       REP_LAST    = REP_W'(`IPOD_REPEAT_CYCLES - 1);

  logic [2:0]             key_meta;
  logic [2:0]             key_sync;
  logic                   faster_held;
  logic                   slower_held;
  logic                   default_held;
  logic [REP_W-1:0]       repeat_cnt;
  logic                   repeat_wrap;
  logic [`IPOD_DIV_W-1:0] period_cnt;

  // ==========================================================================
  // Key synchronizers, idle high
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key_n;
      key_sync <= key_meta;
    end
  end

  assign faster_held  = ~key_sync[0];
  assign slower_held  = ~key_sync[1];
  assign default_held = ~key_sync[2];

  // ==========================================================================
  // Step spacing and divisor register
  // ==========================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  assign repeat_wrap = (repeat_cnt == REP_LAST);

  always_ff @(posedge CLK_50M)
  begin
    if (reset || default_held)
      divisor <= DIV_DEFAULT;
    else if (repeat_wrap && faster_held)
      divisor <= (divisor >= DIV_MIN + DIV_STEP) ? divisor - DIV_STEP : DIV_MIN;
    else if (repeat_wrap && slower_held)
      divisor <= (divisor <= DIV_MAX - DIV_STEP) ? divisor + DIV_STEP : DIV_MAX;
  end

  // Sample period, one tick every divisor cycles
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      period_cnt  <= DIV_DEFAULT - 1'b1;
      sample_tick <= 1'b0;
    end
    else if (period_cnt == '0)
    begin
      period_cnt  <= divisor - 1'b1;
      sample_tick <= 1'b1;
    end
    else
    begin
      period_cnt  <= period_cnt - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/flash_reader.sv */
`default_nettype none
`timescale 1ns/100ps

module flash_reader
  import ipod_flash_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic        fetch,
  input  flash_addr_t word_addr,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output flash_word_t word,
  output logic        word_valid
);

  flash_state_e state;
  logic         accept;
  logic         capture;

  // Requests are only taken while idle
  assign accept  = (state == FLASH_IDLE) && fetch;
  assign capture = (state == FLASH_WAIT_DATA) && flash_readdatavalid;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state      <= FLASH_IDLE;
      flash_read <= 1'b0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= capture;
      case (state)
        FLASH_IDLE:
          if (accept)
          begin
            flash_read <= 1'b1;
            state      <= FLASH_REQUEST;
          end
        // Read and address held until the slave stops stalling
        FLASH_REQUEST:
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= FLASH_WAIT_DATA;
          end
        FLASH_WAIT_DATA:
          if (flash_readdatavalid)
            state <= FLASH_IDLE;
        default:
          state <= FLASH_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (accept)
      flash_address <= word_addr;
    if (capture)
      word <= flash_readdata;
  end

endmodule

`default_nettype wire

/* source/sample_sequencer.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module sample_sequencer
  import ipod_flash_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          reset,
  input  logic          paused,
  input  logic          reverse,
  input  logic          restart,
  input  logic          sample_tick,
  input  flash_word_t   word,
  input  logic          word_valid,
  output logic          fetch,
  output flash_addr_t   word_addr,
  output audio_sample_t audio_sample,
  output logic          sample_strobe
);

  localparam flash_addr_t ADDR_LAST = flash_addr_t'(`IPOD_FLASH_WORDS - 1);
  localparam logic [1:0]  IDX_LOW   = 2'd0;
  localparam logic [1:0]  IDX_HIGH  = 2'd3;

  flash_word_t word_buf;
  flash_addr_t next_addr;
  logic [1:0]  byte_idx;
  logic        buf_valid;
  logic        need_fetch;
  logic        in_flight;
  logic        discard;
  logic        play_rev;
  logic        last_byte;
  logic        load_word;
  logic        emit;

  // Stale words from before a restart are dropped
  assign load_word = word_valid && !discard && !restart;
  assign emit      = sample_tick && buf_valid && !paused && !restart;
  assign last_byte = play_rev ? (byte_idx == IDX_LOW) : (byte_idx == IDX_HIGH);

  always_comb
  begin
    if (reverse)
      next_addr = (word_addr == '0) ? ADDR_LAST : word_addr - 1'b1;
    else
      next_addr = (word_addr == ADDR_LAST) ? '0 : word_addr + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      word_addr     <= '0;
      play_rev      <= 1'b0;
      buf_valid     <= 1'b0;
      need_fetch    <= 1'b1;
      in_flight     <= 1'b0;
      discard       <= 1'b0;
      fetch         <= 1'b0;
      byte_idx      <= IDX_LOW;
      sample_strobe <= 1'b0;
    end
    else
    begin
      fetch         <= 1'b0;
      sample_strobe <= emit;
      if (word_valid)
        in_flight <= 1'b0;
      if (restart)
      begin
        word_addr  <= reverse ? ADDR_LAST : '0;
        play_rev   <= reverse;
        buf_valid  <= 1'b0;
        need_fetch <= 1'b1;
        discard    <= in_flight && !word_valid;
      end
      else
      begin
        if (need_fetch && !in_flight)
        begin
          fetch      <= 1'b1;
          in_flight  <= 1'b1;
          need_fetch <= 1'b0;
        end
        if (word_valid)
          discard <= 1'b0;
        if (load_word)
        begin
          buf_valid <= 1'b1;
          byte_idx  <= play_rev ? IDX_HIGH : IDX_LOW;
        end
        // Word boundary, direction is picked up here
        if (emit && last_byte)
        begin
          buf_valid  <= 1'b0;
          word_addr  <= next_addr;
          play_rev   <= reverse;
          need_fetch <= 1'b1;
        end
        else if (emit)
          byte_idx <= play_rev ? byte_idx - 1'b1 : byte_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (load_word)
      word_buf <= word;
    if (emit)
      audio_sample <= word_buf[byte_idx * `IPOD_SAMPLE_W +: `IPOD_SAMPLE_W];
  end

endmodule

`default_nettype wire

/* source/hex_display.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module hex_display
(
  input  logic                   CLK_50M,
  input  logic [`IPOD_DIV_W-1:0] divisor,
  output logic [6:0]             hex0,
  output logic [6:0]             hex1,
  output logic [6:0]             hex2,
  output logic [6:0]             hex3
);

  logic [6:0] seg_q [`IPOD_HEX_DIGITS];

  // Active low, gfedcba
  function automatic logic [6:0] hex_glyph(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < `IPOD_HEX_DIGITS; i++)
      seg_q[i] <= hex_glyph(divisor[4*i +: 4]);
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];

endmodule

`default_nettype wire

/* source/simple_ipod_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module simple_ipod_top
  import ipod_flash_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     reset,
  input  logic [`IPOD_ASCII_W-1:0] kbd_ascii,
  input  logic                     kbd_valid,
  input  logic [2:0]               key_n,
  output logic                     flash_read,
  output flash_addr_t              flash_address,
  input  logic                     flash_waitrequest,
  input  flash_word_t              flash_readdata,
  input  logic                     flash_readdatavalid,
  output audio_sample_t            audio_sample,
  output logic                     sample_strobe,
  output logic                     led_paused,
  output logic                     led_reverse,
  output logic [6:0]               hex0,
  output logic [6:0]               hex1,
  output logic [6:0]               hex2,
  output logic [6:0]               hex3
);

  logic                   restart;
  logic [`IPOD_DIV_W-1:0] divisor;
  logic                   sample_tick;
  logic                   fetch;
  flash_addr_t            word_addr;
  flash_word_t            word;
  logic                   word_valid;

  // ==========================================================================
  // Control
  // ==========================================================================
  player_command_decoder u_cmd (
    .CLK_50M (CLK_50M), .reset (reset),
    .kbd_ascii (kbd_ascii), .kbd_valid (kbd_valid),
    .paused (led_paused), .reverse (led_reverse), .restart (restart)
  );

  playback_rate_control u_rate (
    .CLK_50M (CLK_50M), .reset (reset), .key_n (key_n),
    .divisor (divisor), .sample_tick (sample_tick)
  );

  // ==========================================================================
  // Flash to audio path
  // ==========================================================================
  flash_reader u_reader (
    .CLK_50M (CLK_50M), .reset (reset), .fetch (fetch), .word_addr (word_addr),
    .flash_read (flash_read), .flash_address (flash_address),
    .flash_waitrequest (flash_waitrequest), .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid), .word (word), .word_valid (word_valid)
  );

  sample_sequencer u_seq (
    .CLK_50M (CLK_50M), .reset (reset), .paused (led_paused), .reverse (led_reverse),
    .restart (restart), .sample_tick (sample_tick), .word (word), .word_valid (word_valid),
    .fetch (fetch), .word_addr (word_addr), .audio_sample (audio_sample),
    .sample_strobe (sample_strobe)
  );

  hex_display u_hex (
    .CLK_50M (CLK_50M), .divisor (divisor),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3)
  );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen
#(
  parameter int HALF_PERIOD = 10
)
(
  output logic CLK_50M
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #HALF_PERIOD CLK_50M = ~CLK_50M;
  end

endmodule

`default_nettype wire

/* sim/simple_ipod_asserts.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module simple_ipod_asserts
  import ipod_cmd_pkg::*;
  import ipod_flash_pkg::*;
(
  input logic                     CLK_50M,
  input logic                     reset,
  input logic [`IPOD_ASCII_W-1:0] kbd_ascii,
  input logic                     kbd_valid,
  input logic                     led_paused,
  input logic                     led_reverse,
  input logic                     sample_strobe,
  input logic                     flash_read,
  input flash_addr_t              flash_address,
  input logic                     flash_waitrequest,
  input logic [`IPOD_DIV_W-1:0]   divisor
);

  cmd_e kbd_cmd;
  int   fail_count = 0;

  function automatic cmd_e to_cmd(input logic [`IPOD_ASCII_W-1:0] code);
    case (code)
      "E", "e": return CMD_PLAY;
      "D", "d": return CMD_PAUSE;
      "F", "f": return CMD_FORWARD;
      "B", "b": return CMD_BACKWARD;
      "R", "r": return CMD_RESTART;
      default:  return CMD_NONE;
    endcase
  endfunction

  assign kbd_cmd = kbd_valid ? to_cmd(kbd_ascii) : CMD_NONE;

  // ==========================================================================
  // Command levels
  // ==========================================================================
  a_play: assert property (@(posedge CLK_50M) disable iff (reset)
    kbd_cmd == CMD_PLAY |=> !led_paused)
    else
    begin
      $error("play command did not clear led_paused");
      fail_count++;
    end

  a_pause: assert property (@(posedge CLK_50M) disable iff (reset)
    kbd_cmd == CMD_PAUSE |=> led_paused)
    else
    begin
      $error("pause command did not set led_paused");
      fail_count++;
    end

  a_backward: assert property (@(posedge CLK_50M) disable iff (reset)
    kbd_cmd == CMD_BACKWARD |=> led_reverse)
    else
    begin
      $error("backward command did not set led_reverse");
      fail_count++;
    end

  a_forward: assert property (@(posedge CLK_50M) disable iff (reset)
    kbd_cmd == CMD_FORWARD |=> !led_reverse)
    else
    begin
      $error("forward command did not clear led_reverse");
      fail_count++;
    end

  // Strobe lags the pause level by one cycle
  a_no_strobe_paused: assert property (@(posedge CLK_50M) disable iff (reset)
    $past(led_paused) |-> !sample_strobe)
    else
    begin
      $error("sample strobe while paused");
      fail_count++;
    end

  // ==========================================================================
  // Flash bus and divisor range
  // ==========================================================================
  a_flash_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else
    begin
      $error("flash request dropped or changed during waitrequest");
      fail_count++;
    end

  a_divisor_range: assert property (@(posedge CLK_50M) disable iff (reset)
    divisor >= `IPOD_DIVISOR_MIN && divisor <= `IPOD_DIVISOR_MAX)
    else
    begin
      $error("divisor left its allowed range");
      fail_count++;
    end

endmodule

`default_nettype wire

/* sim/tb_simple_ipod.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ipod_params.svh"

module tb_simple_ipod
  import ipod_flash_pkg::*;
;

  localparam int SEED         = 32'h88c5;
  localparam int DIV_DEF      = `IPOD_DIVISOR_DEFAULT;
  localparam int REP          = `IPOD_REPEAT_CYCLES;
  localparam int PLAY_SAMPLES = 40;

  // Test lengths in cycles
  localparam int LEN_RESET    = 24;
  localparam int LEN_COMMANDS = 64;
  localparam int LEN_PLAY     = (PLAY_SAMPLES + 4) * DIV_DEF;
  localparam int LEN_PAUSE    = 4 * DIV_DEF;
  localparam int LEN_RATE     = (3 + 5 + 130 + 380) * REP + 256;
  // Twice the summed test lengths
  localparam int TIMEOUT_CYCLES =
    2 * (LEN_RESET + LEN_COMMANDS + 2 * LEN_PLAY + LEN_PAUSE + LEN_RATE);

  logic                     CLK_50M;
  logic                     reset;
  logic [`IPOD_ASCII_W-1:0] kbd_ascii;
  logic                     kbd_valid;
  logic [2:0]               key_n;
  logic                     flash_read;
  flash_addr_t              flash_address;
  logic                     flash_waitrequest = 1'b1;
  flash_word_t              flash_readdata = '0;
  logic                     flash_readdatavalid = 1'b0;
  audio_sample_t            audio_sample;
  logic                     sample_strobe;
  logic                     led_paused;
  logic                     led_reverse;
  logic [6:0]               hex0;
  logic [6:0]               hex1;
  logic [6:0]               hex2;
  logic [6:0]               hex3;

  int            errors;
  int            test_errors;
  int            tests_run;
  int            tests_failed;
  int            assert_fails_seen;
  int            cycles;
  int            samples_seen;
  int            valid_delay;
  int            expected_div;
  int            held;
  flash_addr_t   pend_addr;
  logic [31:0]   rnd;
  logic          have_prev;
  logic          first_pending;
  logic          play_down;
  audio_sample_t prev_sample;
  audio_sample_t first_expect;
  audio_sample_t expected_sample;

  tb_clock_gen clk_gen (.CLK_50M (CLK_50M));

  simple_ipod_top uut (
    .CLK_50M (CLK_50M), .reset (reset), .kbd_ascii (kbd_ascii), .kbd_valid (kbd_valid),
    .key_n (key_n), .flash_read (flash_read), .flash_address (flash_address),
    .flash_waitrequest (flash_waitrequest), .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid), .audio_sample (audio_sample),
    .sample_strobe (sample_strobe), .led_paused (led_paused), .led_reverse (led_reverse),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3)
  );

  bind simple_ipod_top simple_ipod_asserts u_asserts (
    .CLK_50M (CLK_50M), .reset (reset), .kbd_ascii (kbd_ascii), .kbd_valid (kbd_valid),
    .led_paused (led_paused), .led_reverse (led_reverse), .sample_strobe (sample_strobe),
    .flash_read (flash_read), .flash_address (flash_address),
    .flash_waitrequest (flash_waitrequest), .divisor (divisor)
  );

  // ==========================================================================
  // Reference values
  // ==========================================================================
  // Bytes 4a to 4a+3 with the low byte first
  function automatic flash_word_t flash_word(input flash_addr_t addr);
    flash_word_t w;
    logic [7:0]  base;
    base = {addr[5:0], 2'b00};
    for (int i = 0; i < 4; i++)
      w[8*i +: 8] = base + 8'(i);
    return w;
  endfunction

  // Standard glyphs in active low gfedcba order
  function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  function automatic int stepped_divisor(input int div, input int steps, input bit down);
    int d;
    d = div;
    for (int i = 0; i < steps; i++)
    begin
      if (down)
        d = (d - `IPOD_DIVISOR_STEP < `IPOD_DIVISOR_MIN) ?
            `IPOD_DIVISOR_MIN : d - `IPOD_DIVISOR_STEP;
      else
        d = (d + `IPOD_DIVISOR_STEP > `IPOD_DIVISOR_MAX) ?
            `IPOD_DIVISOR_MAX : d + `IPOD_DIVISOR_STEP;
    end
    return d;
  endfunction

  // ==========================================================================
  // Reporting and stimulus tasks
  // ==========================================================================
  task automatic note_mismatch(input string what, input int got, input int want);
    $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, want);
    errors++;
    test_errors++;
  endtask

  // Bound assertion failures count against the test that just ran
  task automatic finish_test(input string name);
    int new_fails;
    new_fails = uut.u_asserts.fail_count - assert_fails_seen;
    assert_fails_seen = uut.u_asserts.fail_count;
    test_errors += new_fails;
    errors += new_fails;
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("Test %-12s %s, %0d errors", name, (test_errors == 0) ? "passed" : "FAILED",
             test_errors);
    test_errors = 0;
  endtask

  task automatic send_command(input logic [7:0] code);
    @(negedge CLK_50M);
    kbd_ascii = code;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
    kbd_ascii = '0;
  endtask

  // Holding for a multiple of the repeat spacing gives an exact step count
  task automatic hold_key(input int idx, input int n_cycles);
    @(negedge CLK_50M);
    key_n[idx] = 1'b0;
    repeat (n_cycles) @(negedge CLK_50M);
    key_n[idx] = 1'b1;
    repeat (4) @(negedge CLK_50M);
  endtask

  task automatic check_display(input int div);
    logic [15:0] d;
    logic [6:0]  shown [4];
    logic [6:0]  want;
    d = 16'(div);
    shown[0] = hex0;
    shown[1] = hex1;
    shown[2] = hex2;
    shown[3] = hex3;
    for (int i = 0; i < 4; i++)
    begin
      want = seg_pattern(d[4*i +: 4]);
      assert (shown[i] == want)
        else note_mismatch($sformatf("hex%0d segments", i), int'(shown[i]), int'(want));
    end
  endtask

  task automatic wait_samples(input int count);
    int target;
    target = samples_seen + count;
    while (samples_seen < target)
      @(negedge CLK_50M);
  endtask

  // Only called while paused with no strobe in flight
  task automatic arm_order(input logic [7:0] start, input logic down);
    first_expect  = start;
    first_pending = 1'b1;
    have_prev     = 1'b0;
    play_down     = down;
  endtask

  // ==========================================================================
  // Flash model with random stall and data latency
  // ==========================================================================
  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    if (reset)
    begin
      valid_delay       = 0;
      flash_waitrequest = 1'b1;
    end
    else
    begin
      if (valid_delay > 0)
      begin
        valid_delay--;
        if (valid_delay == 0)
        begin
          flash_readdatavalid = 1'b1;
          flash_readdata      = flash_word(pend_addr);
        end
      end
      rnd = $urandom;
      flash_waitrequest = rnd[0];
      // Request taken on the coming rising edge
      if (flash_read && !flash_waitrequest)
      begin
        pend_addr   = flash_address;
        valid_delay = 1 + int'(rnd[9:8]);
      end
    end
  end

  // Sample order monitor
  always @(negedge CLK_50M)
  begin
    if (!reset && sample_strobe)
    begin
      if (first_pending)
      begin
        assert (audio_sample == first_expect)
          else note_mismatch("first sample", int'(audio_sample), int'(first_expect));
        first_pending = 1'b0;
      end
      else if (have_prev)
      begin
        expected_sample = play_down ? prev_sample - 8'd1 : prev_sample + 8'd1;
        assert (audio_sample == expected_sample)
          else note_mismatch("sample order", int'(audio_sample), int'(expected_sample));
      end
      prev_sample = audio_sample;
      have_prev   = 1'b1;
      samples_seen++;
    end
  end

  always @(posedge CLK_50M)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial
  begin
    void'($urandom(SEED));
    reset             = 1'b1;
    kbd_ascii         = '0;
    kbd_valid         = 1'b0;
    key_n             = 3'b111;
    errors            = 0;
    test_errors       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    assert_fails_seen = 0;
    cycles            = 0;
    samples_seen      = 0;
    have_prev         = 1'b0;
    first_pending     = 1'b0;
    play_down         = 1'b0;
    repeat (16) @(negedge CLK_50M);
    reset = 1'b0;

    assert (led_paused == 1'b1) else note_mismatch("led_paused", int'(led_paused), 1);
    assert (led_reverse == 1'b0) else note_mismatch("led_reverse", int'(led_reverse), 0);
    assert (sample_strobe == 1'b0)
      else note_mismatch("sample_strobe", int'(sample_strobe), 0);
    check_display(DIV_DEF);
    finish_test("reset_state");

    send_command("e");
    assert (led_paused == 1'b0) else note_mismatch("play", int'(led_paused), 0);
    send_command("D");
    assert (led_paused == 1'b1) else note_mismatch("pause", int'(led_paused), 1);
    send_command("B");
    assert (led_reverse == 1'b1) else note_mismatch("backward", int'(led_reverse), 1);
    send_command("f");
    assert (led_reverse == 1'b0) else note_mismatch("forward", int'(led_reverse), 0);
    send_command("x");
    assert (led_paused == 1'b1) else note_mismatch("ignored code", int'(led_paused), 1);
    finish_test("commands");

    send_command("R");
    repeat (8) @(negedge CLK_50M);
    arm_order(8'd0, 1'b0);
    send_command("E");
    wait_samples(PLAY_SAMPLES);
    finish_test("forward");

    send_command("d");
    repeat (4) @(negedge CLK_50M);
    held = samples_seen;
    repeat (3 * DIV_DEF) @(negedge CLK_50M);
    assert (samples_seen == held) else note_mismatch("samples while paused", samples_seen, held);
    finish_test("pause_hold");

    // Reverse start is the high byte of the last word
    send_command("b");
    send_command("r");
    repeat (8) @(negedge CLK_50M);
    arm_order(8'(4 * (`IPOD_FLASH_WORDS - 1) + 3), 1'b1);
    send_command("E");
    wait_samples(PLAY_SAMPLES);
    finish_test("reverse");

    expected_div = stepped_divisor(DIV_DEF, 3, 1'b1);
    hold_key(0, 3 * REP);
    check_display(expected_div);
    expected_div = stepped_divisor(expected_div, 5, 1'b0);
    hold_key(1, 5 * REP);
    check_display(expected_div);
    hold_key(2, 4);
    check_display(DIV_DEF);
    expected_div = stepped_divisor(DIV_DEF, 130, 1'b1);
    hold_key(0, 130 * REP);
    check_display(expected_div);
    hold_key(2, 4);
    expected_div = stepped_divisor(DIV_DEF, 380, 1'b0);
    hold_key(1, 380 * REP);
    check_display(expected_div);
    hold_key(2, 4);
    check_display(DIV_DEF);
    finish_test("rate_control");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/ipod_cmd_pkg.sv
source/ipod_flash_pkg.sv
source/player_command_decoder.sv
source/playback_rate_control.sv
source/flash_reader.sv
source/sample_sequencer.sv
source/hex_display.sv
source/simple_ipod_top.sv
sim/tb_clock_gen.sv
sim/simple_ipod_asserts.sv
sim/tb_simple_ipod.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the result"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module tb_simple_ipod -f filelist.f -o sim_ipod
	@out="$$(./obj_dir/sim_ipod)"; echo "$$out"; \
	  echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
